/* files.f */
+incdir+.
mem_pkg.sv
mem_interface.sv
data_mem.sv
load_align.sv
mem_stage.sv
tb_mem_stage.sv

/* run.sh */
#!/bin/sh
# builds the data-memory stage testbench with Verilator and runs it
# exit status is nonzero when the simulation ends in $fatal
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_mem_stage -o tb_mem_stage

./obj_dir/tb_mem_stage

/* tb_mem_stage.sv */
//----------------------------------------------------------------------
// random traffic from a fixed seed against a byte-array memory model
// outputs compared at the falling edge 2 cycles after each issue
//----------------------------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module tb_mem_stage;

    localparam int MEM_BYTES  = `MEM_DEPTH_WORDS * 4;
    localparam int NUM_OPS    = 6000;
    localparam int MAX_CYCLES = NUM_OPS + 100;

    logic             clk = 1'b0;
    logic             nrst;
    mem_pkg::mem_op_t i_mem_op;
    mem_pkg::word_t   i_base;
    mem_pkg::word_t   i_src;
    mem_pkg::word_t   i_s_imm;
    mem_pkg::word_t   o_load_data;
    logic             o_load_valid;
    logic             o_ld_misaligned;
    logic             o_st_misaligned;
    mem_pkg::word_t   o_addr;

    // reference memory with one entry per byte
    logic [7:0] model_mem [MEM_BYTES];

    // expected stage 6 results in a 2-deep delay line
    mem_pkg::word_t exp_addr_q[$];
    mem_pkg::word_t exp_data_q[$];
    logic           exp_valid_q[$];
    logic           exp_ldm_q[$];
    logic           exp_stm_q[$];

    mem_stage u_dut (
        .clk             (clk),
        .nrst            (nrst),
        .i_mem_op        (i_mem_op),
        .i_base          (i_base),
        .i_src           (i_src),
        .i_s_imm         (i_s_imm),
        .o_load_data     (o_load_data),
        .o_load_valid    (o_load_valid),
        .o_ld_misaligned (o_ld_misaligned),
        .o_st_misaligned (o_st_misaligned),
        .o_addr          (o_addr)
    );

    always #10 clk = ~clk;

    // nine legal codes plus one illegal
    function automatic mem_pkg::mem_op_t random_op_code(input int unsigned sel);
        case (sel)
            0: return `MEM_OP_NONE;
            1: return `MEM_OP_LB;
            2: return `MEM_OP_LH;
            3: return `MEM_OP_LW;
            4: return `MEM_OP_LBU;
            5: return `MEM_OP_LHU;
            6: return `MEM_OP_SW;
            7: return `MEM_OP_SB;
            8: return `MEM_OP_SH;
            default: return 4'd6;
        endcase
    endfunction

    // bytes touched by an access or zero for no-op codes
    function automatic int access_size(input mem_pkg::mem_op_t op);
        case (op)
            `MEM_OP_LB, `MEM_OP_LBU, `MEM_OP_SB: return 1;
            `MEM_OP_LH, `MEM_OP_LHU, `MEM_OP_SH: return 2;
            `MEM_OP_LW, `MEM_OP_SW:              return 4;
            default:                             return 0;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input mem_pkg::word_t exp_val,
                                   input mem_pkg::word_t got_val);
        $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp_val, got_val);
        $display("** FAIL **");
        $fatal(1, "stage 6 output check failed");
    endtask

    task automatic check_outputs(input mem_pkg::word_t e_addr, input mem_pkg::word_t e_data,
                                 input logic e_valid, input logic e_ldm, input logic e_stm);
        assert (o_addr === e_addr)
            else report_mismatch("o_addr", e_addr, o_addr);
        assert (o_load_valid === e_valid)
            else report_mismatch("o_load_valid", {31'b0, e_valid}, {31'b0, o_load_valid});
        assert (o_ld_misaligned === e_ldm)
            else report_mismatch("o_ld_misaligned", {31'b0, e_ldm}, {31'b0, o_ld_misaligned});
        assert (o_st_misaligned === e_stm)
            else report_mismatch("o_st_misaligned", {31'b0, e_stm}, {31'b0, o_st_misaligned});
        assert (o_load_data === e_data)
            else report_mismatch("o_load_data", e_data, o_load_data);
    endtask

    task automatic push_expected(input mem_pkg::word_t addr, input mem_pkg::word_t data,
                                 input logic valid, input logic ldm, input logic stm);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_valid_q.push_back(valid);
        exp_ldm_q.push_back(ldm);
        exp_stm_q.push_back(stm);
    endtask

    // drive one operation and predict its stage 6 result in program order
    task automatic issue_op(input mem_pkg::mem_op_t op, input mem_pkg::word_t base,
                            input mem_pkg::word_t src, input mem_pkg::word_t s_imm);
        mem_pkg::word_t            addr;
        mem_pkg::word_t            data;
        logic [`MEM_ADDR_BITS+1:0] ba;
        logic [`MEM_ADDR_BITS+1:0] idx;
        int                        size;
        logic                      is_load;
        logic                      is_store;
        logic                      mis;

        i_mem_op <= op;
        i_base   <= base;
        i_src    <= src;
        i_s_imm  <= s_imm;
        is_store = (op == `MEM_OP_SB) || (op == `MEM_OP_SH) || (op == `MEM_OP_SW);
        is_load  = (op == `MEM_OP_LB) || (op == `MEM_OP_LH) || (op == `MEM_OP_LW) ||
                   (op == `MEM_OP_LBU) || (op == `MEM_OP_LHU);
        size = access_size(op);
        // stores take the S offset and all other codes take src
        addr = is_store ? base + s_imm : base + src;
        mis  = (size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00);
        // upper address bits alias
        ba   = addr[`MEM_ADDR_BITS+1:0];
        data = '0;
        if (is_load && !mis) begin
            for (int k = 0; k < size; k++) begin
                idx  = ba + k[`MEM_ADDR_BITS+1:0];
                data = data | (mem_pkg::word_t'(model_mem[idx]) << (8 * k));
            end
            case (op)
                `MEM_OP_LB: data = {{24{data[7]}}, data[7:0]};
                `MEM_OP_LH: data = {{16{data[15]}}, data[15:0]};
                default: ;
            endcase
        end
        // misaligned stores leave the model untouched
        if (is_store && !mis) begin
            for (int k = 0; k < size; k++) begin
                idx = ba + k[`MEM_ADDR_BITS+1:0];
                model_mem[idx] = 8'(src >> (8 * k));
            end
        end
        push_expected(addr, data, is_load && !mis, is_load && mis, is_store && mis);
    endtask

    task automatic check_stage6();
        check_outputs(exp_addr_q.pop_front(), exp_data_q.pop_front(),
                      exp_valid_q.pop_front(), exp_ldm_q.pop_front(), exp_stm_q.pop_front());
    endtask

    initial begin
        mem_pkg::mem_op_t op;
        mem_pkg::word_t   base;
        mem_pkg::word_t   src;
        mem_pkg::word_t   s_imm;
        int               off;
        int               cycles;
        int               issued;

        nrst     = 1'b0;
        i_mem_op = `MEM_OP_NONE;
        i_base   = '0;
        i_src    = '0;
        i_s_imm  = '0;
        void'($urandom(32'h60724c6c));
        for (int i = 0; i < MEM_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        // pipeline holds reset zeros for the first two slots
        push_expected('0, '0, 1'b0, 1'b0, 1'b0);
        push_expected('0, '0, 1'b0, 1'b0, 1'b0);

        // outputs stay idle while in reset
        repeat (7) begin
            @(negedge clk);
            check_outputs('0, '0, 1'b0, 1'b0, 1'b0);
        end
        @(posedge clk);
        nrst <= 1'b1;

        cycles = 0;
        issued = 0;
        while (issued < NUM_OPS + 2) begin
            if (cycles >= MAX_CYCLES) begin
                $display("timeout: run loop exceeded %0d cycles", MAX_CYCLES);
                $display("** FAIL **");
                $fatal(1, "run loop timeout");
            end
            @(posedge clk);
            // last two slots just drain the pipeline
            op   = (issued < NUM_OPS) ? random_op_code($urandom % 10) : `MEM_OP_NONE;
            base = 32'h40 + ($urandom % 48);
            // high bits now and then so the memory aliases
            if ($urandom % 8 == 0) begin
                base[31:12] = 20'($urandom);
            end
            off = int'($urandom % 24) - 8;
            // bias toward aligned accesses so stores land
            if ($urandom % 4 != 0) begin
                base[1:0] = 2'b00;
                off = off & ~3;
            end
            // unused operand gets noise
            s_imm = op[3] ? mem_pkg::word_t'(off) : $urandom;
            src   = op[3] ? $urandom : mem_pkg::word_t'(off);
            issue_op(op, base, src, s_imm);
            issued++;
            @(negedge clk);
            check_stage6();
            cycles++;
        end

        $display("** PASS **");
        $finish;
    end

endmodule

/* mem_stage.sv */
//--------------------------------------------------------------------
// memory stage top, results 2 cycles after the inputs are sampled
// no back-pressure, one operation accepted every clock
//--------------------------------------------------------------------

`timescale 1ns/1ps

module mem_stage (
    input  logic             clk,
    input  logic             nrst,
    input  mem_pkg::mem_op_t i_mem_op,
    input  mem_pkg::word_t   i_base,
    input  mem_pkg::word_t   i_src,
    input  mem_pkg::word_t   i_s_imm,
    output mem_pkg::word_t   o_load_data,
    output logic             o_load_valid,
    output logic             o_ld_misaligned,
    output logic             o_st_misaligned,
    output mem_pkg::word_t   o_addr
);

    // stage 6 controls
    mem_pkg::word_t    addr_6;
    mem_pkg::word_t    wdata_6;
    logic              we_6;
    logic              rd_6;
    mem_pkg::byte_en_t byte_en_6;
    mem_pkg::mem_op_t  mem_op_6;

    // raw word from memory
    mem_pkg::word_t    rdata_6;

    // address, strobes and store data
    mem_interface u_mem_interface (
        .clk             (clk),
        .nrst            (nrst),
        .i_mem_op        (i_mem_op),
        .i_base          (i_base),
        .i_src           (i_src),
        .i_s_imm         (i_s_imm),
        .o_addr          (addr_6),
        .o_wdata         (wdata_6),
        .o_we            (we_6),
        .o_rd            (rd_6),
        .o_byte_en       (byte_en_6),
        .o_mem_op        (mem_op_6),
        .o_ld_misaligned (o_ld_misaligned),
        .o_st_misaligned (o_st_misaligned)
    );

    data_mem u_data_mem (
        .clk       (clk),
        .nrst      (nrst),
        .i_we      (we_6),
        .i_rd      (rd_6),
        .i_byte_en (byte_en_6),
        .i_addr    (addr_6),
        .i_wdata   (wdata_6),
        .o_rdata   (rdata_6)
    );

    // lane select and extension of the loaded word
    load_align u_load_align (
        .i_mem_op    (mem_op_6),
        .i_byte_off  (addr_6[1:0]),
        .i_rd        (rd_6),
        .i_rdata     (rdata_6),
        .o_load_data (o_load_data)
    );

    // read strobe doubles as load valid
    assign o_load_valid = rd_6;
    // kept for the exception value
    assign o_addr       = addr_6;

endmodule

/* load_align.sv */
//--------------------------------------------------------------------
// purely combinational, halfword offset assumed aligned upstream
// output is zero whenever the read strobe is low
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module load_align (
    input  mem_pkg::mem_op_t   i_mem_op,
    input  mem_pkg::byte_off_t i_byte_off,
    input  logic               i_rd,
    input  mem_pkg::word_t     i_rdata,
    output mem_pkg::word_t     o_load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // addressed byte lane
    assign byte_sel = i_rdata[8*i_byte_off +: 8];

    // bit 1 picks upper or lower half
    assign half_sel = i_byte_off[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb begin
        o_load_data = '0;
        if (i_rd) begin
            case (i_mem_op)
                // sign extension
                `MEM_OP_LB:  o_load_data = {{24{byte_sel[7]}}, byte_sel};
                `MEM_OP_LH:  o_load_data = {{16{half_sel[15]}}, half_sel};
                // zero extension
                `MEM_OP_LBU: o_load_data = {24'b0, byte_sel};
                `MEM_OP_LHU: o_load_data = {16'b0, half_sel};
                // full word untouched
                `MEM_OP_LW:  o_load_data = i_rdata;
                default:     o_load_data = '0;
            endcase
        end
    end

endmodule

/* data_mem.sv */
//--------------------------------------------------------------------
// word memory, byte-lane write at the clock edge, async read
// address bits above the depth are ignored, so the array aliases
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module data_mem (
    input  logic              clk,
    input  logic              nrst,
    input  logic              i_we,
    input  logic              i_rd,
    input  mem_pkg::byte_en_t i_byte_en,
    input  mem_pkg::word_t    i_addr,
    input  mem_pkg::word_t    i_wdata,
    output mem_pkg::word_t    o_rdata
);

    mem_pkg::word_t mem [`MEM_DEPTH_WORDS];

    // word index, byte offset bits dropped
    logic [`MEM_ADDR_BITS-1:0] word_idx;

    assign word_idx = i_addr[`MEM_ADDR_BITS+1:2];

    // reset brings the array to all zeros
    // writes land at the edge closing stage 6
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            // only enabled lanes change
            for (int n = 0; n < 4; n++) begin
                if (i_byte_en[n]) begin
                    mem[word_idx][8*n +: 8] <= i_wdata[8*n +: 8];
                end
            end
        end
    end

    // read data held at zero without a read strobe
    assign o_rdata = i_rd ? mem[word_idx] : '0;

endmodule

/* mem_interface.sv */
//--------------------------------------------------------------------
// two register stages, fixed 2-cycle latency, no stall or flush
// misaligned accesses are flagged and never reach the memory
//--------------------------------------------------------------------

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_interface (
    input  logic               clk,
    input  logic               nrst,
    input  mem_pkg::mem_op_t   i_mem_op,
    input  mem_pkg::word_t     i_base,
    input  mem_pkg::word_t     i_src,
    input  mem_pkg::word_t     i_s_imm,
    output mem_pkg::word_t     o_addr,
    output mem_pkg::word_t     o_wdata,
    output logic               o_we,
    output logic               o_rd,
    output mem_pkg::byte_en_t  o_byte_en,
    output mem_pkg::mem_op_t   o_mem_op,
    output logic               o_ld_misaligned,
    output logic               o_st_misaligned
);

    // stage 5 registers
    mem_pkg::mem_op_t  mem_op_r5;
    mem_pkg::word_t    base_r5;
    mem_pkg::word_t    src_r5;
    mem_pkg::word_t    s_imm_r5;

    // stage 5 decode
    logic is_lb, is_lh, is_lw, is_lbu, is_lhu;
    logic is_sb, is_sh, is_sw;
    logic is_load, is_store;

    // stage 5 derived controls
    mem_pkg::word_t    addr_5;
    mem_pkg::byte_off_t off_5;
    logic              half_mis_5;
    logic              word_mis_5;
    logic              ld_mis_5;
    logic              st_mis_5;
    logic              we_5;
    logic              rd_5;
    mem_pkg::byte_en_t byte_en_5;
    mem_pkg::word_t    wdata_5;

    // stage 6 registers
    mem_pkg::word_t    addr_r6;
    mem_pkg::word_t    wdata_r6;
    logic              we_r6;
    logic              rd_r6;
    mem_pkg::byte_en_t byte_en_r6;
    mem_pkg::mem_op_t  mem_op_r6;
    logic              ld_mis_r6;
    logic              st_mis_r6;

    // capture operands from stage 4
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            mem_op_r5 <= '0;
            base_r5   <= '0;
            src_r5    <= '0;
            s_imm_r5  <= '0;
        end else begin
            mem_op_r5 <= i_mem_op;
            base_r5   <= i_base;
            src_r5    <= i_src;
            s_imm_r5  <= i_s_imm;
        end
    end

    // one-hot decode, anything else is a no-op
    assign is_lb  = (mem_op_r5 == `MEM_OP_LB);
    assign is_lh  = (mem_op_r5 == `MEM_OP_LH);
    assign is_lw  = (mem_op_r5 == `MEM_OP_LW);
    assign is_lbu = (mem_op_r5 == `MEM_OP_LBU);
    assign is_lhu = (mem_op_r5 == `MEM_OP_LHU);
    assign is_sb  = (mem_op_r5 == `MEM_OP_SB);
    assign is_sh  = (mem_op_r5 == `MEM_OP_SH);
    assign is_sw  = (mem_op_r5 == `MEM_OP_SW);

    assign is_load  = is_lb | is_lh | is_lw | is_lbu | is_lhu;
    assign is_store = is_sb | is_sh | is_sw;

    // stores use the S immediate, loads take the offset on i_src
    assign addr_5 = mem_op_r5[3] ? (base_r5 + s_imm_r5) : (base_r5 + src_r5);
    assign off_5  = addr_5[1:0];

    // halfword needs bit 0 clear, word needs both low bits clear
    assign half_mis_5 = (is_lh | is_lhu | is_sh) & off_5[0];
    assign word_mis_5 = (is_lw | is_sw) & (off_5 != 2'b00);

    assign ld_mis_5 = is_load & (half_mis_5 | word_mis_5);
    assign st_mis_5 = is_store & (half_mis_5 | word_mis_5);

    // strobes only for aligned accesses
    assign we_5 = is_store & ~st_mis_5;
    assign rd_5 = is_load & ~ld_mis_5;

    // lane enables, all zero unless a write goes out
    always_comb begin
        byte_en_5 = '0;
        if (we_5) begin
            if (is_sb) begin
                byte_en_5 = mem_pkg::byte_en_t'(4'b0001 << off_5);
            end else if (is_sh) begin
                // upper or lower half picked by bit 1
                byte_en_5 = off_5[1] ? 4'b1100 : 4'b0011;
            end else begin
                byte_en_5 = 4'b1111;
            end
        end
    end

    // replicate store data across lanes
    // memory picks the lane through byte_en
    always_comb begin
        wdata_5 = '0;
        if (is_sb) begin
            wdata_5 = {4{src_r5[7:0]}};
        end else if (is_sh) begin
            wdata_5 = {2{src_r5[15:0]}};
        end else if (is_sw) begin
            wdata_5 = src_r5;
        end
    end

    // stage 6 controls towards memory and load path
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            addr_r6    <= '0;
            wdata_r6   <= '0;
            we_r6      <= 1'b0;
            rd_r6      <= 1'b0;
            byte_en_r6 <= '0;
            mem_op_r6  <= '0;
            ld_mis_r6  <= 1'b0;
            st_mis_r6  <= 1'b0;
        end else begin
            addr_r6    <= addr_5;
            wdata_r6   <= wdata_5;
            we_r6      <= we_5;
            rd_r6      <= rd_5;
            byte_en_r6 <= byte_en_5;
            mem_op_r6  <= mem_op_r5;
            ld_mis_r6  <= ld_mis_5;
            st_mis_r6  <= st_mis_5;
        end
    end

    assign o_addr          = addr_r6;
    assign o_wdata         = wdata_r6;
    assign o_we            = we_r6;
    assign o_rd            = rd_r6;
    assign o_byte_en       = byte_en_r6;
    assign o_mem_op        = mem_op_r6;
    assign o_ld_misaligned = ld_mis_r6;
    assign o_st_misaligned = st_mis_r6;

endmodule

/* mem_pkg.sv */
//--------------------------------------------------------------------
// shared vector types for the data-memory stage
// widths follow mem_consts.svh, byte lanes are little endian
//--------------------------------------------------------------------

`include "mem_consts.svh"

package mem_pkg;

    // data word and effective address share one width
    typedef logic [`MEM_DATA_WIDTH-1:0] word_t;

    // memory operation code
    // bit 3 marks a store, unknown codes do nothing
    typedef logic [`MEM_OP_WIDTH-1:0] mem_op_t;

    // one write enable per byte lane
    // bit n enables lane n, i.e. data bits 8n+7:8n
    typedef logic [`MEM_DATA_WIDTH/8-1:0] byte_en_t;

    // byte position inside a word
    typedef logic [1:0] byte_off_t;

endpackage

/* mem_consts.svh */
//--------------------------------------------------------------------
// operation codes and sizes for the data-memory stage
// depth must be a power of two, upper address bits alias
//--------------------------------------------------------------------

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// datapath and op code widths
`define MEM_DATA_WIDTH 32
`define MEM_OP_WIDTH 4

// memory size in 32-bit words
`define MEM_DEPTH_WORDS 256
`define MEM_ADDR_BITS $clog2(`MEM_DEPTH_WORDS)

// op codes, bit 3 set means store
`define MEM_OP_NONE 4'd0
`define MEM_OP_LB 4'd1
`define MEM_OP_LH 4'd2
`define MEM_OP_LW 4'd3
`define MEM_OP_LBU 4'd4
`define MEM_OP_LHU 4'd5
`define MEM_OP_SW 4'd8
`define MEM_OP_SB 4'd14
`define MEM_OP_SH 4'd15

`endif
